// ==== all.f ====
rtl/dma_pkg.sv
rtl/wr_ctrl_if.sv
rtl/wr_rx_ctrl.sv
rtl/wr_realign.sv
rtl/wr_desc_gen.sv
rtl/axis_wr_dma.sv
testbench/tb_axis_wr_dma.sv

// ==== Bender.yml ====
package:
  name: axis_wr_dma

sources:
  # Package and interface first, the blocks import and connect through them
  - rtl/dma_pkg.sv
  - rtl/wr_ctrl_if.sv
  # Receive datapath blocks and the top level
  - rtl/wr_rx_ctrl.sv
  - rtl/wr_realign.sv
  - rtl/wr_desc_gen.sv
  - rtl/axis_wr_dma.sv

  # Testbench with top module tb_axis_wr_dma
  - target: simulation
    files:
      - testbench/tb_axis_wr_dma.sv

// ==== testbench/tb_axis_wr_dma.sv ====
`timescale 1ns/1ps

module tb_axis_wr_dma import dma_pkg::*; ();

  // Four groups of packets: aligned, unaligned, memory stalls, descriptor stalls
  localparam int N_GROUP = 12;
  localparam int N_PKT   = 4 * N_GROUP;
  // Every packet owns its own 64 byte region, so no two packets share an address
  localparam int REGION  = 64;
  localparam int E_DATA  = 0;
  localparam int E_DESC  = 1;
  localparam int E_HS    = 2;
  localparam int E_RST   = 3;

  logic  clk = 1'b0;
  logic  rst;
  data_t s_axis_tdata;
  keep_t s_axis_tkeep;
  logic  s_axis_tvalid;
  logic  s_axis_tready;
  logic  s_axis_tlast;
  dest_t s_axis_tdest;
  user_t s_axis_tuser;
  addr_t wr_base_addr;
  logic  mem_wr_en;
  keep_t mem_wr_strb;
  addr_t mem_wr_addr;
  data_t mem_wr_data;
  logic  mem_wr_last;
  logic  mem_wr_ready;
  logic  recv_desc_valid;
  logic  recv_desc_ready;
  addr_t recv_desc_addr;
  len_t  recv_desc_len;
  dest_t recv_desc_tdest;
  user_t recv_desc_tuser;

  logic [15:0] lfsr = 16'd45125;
  int          errs [4];
  int          cycles;
  int          limit;
  int          desc_cnt;
  int          group;
  logic        beat_taken;

  // Expected memory image, with a flag for every packet byte and for every final byte
  logic [7:0]  exp_byte [0:65535];
  bit          exp_set  [0:65535];
  bit          exp_last [0:65535];
  // Memory model filled by the DUT
  logic [7:0]  wr_mem   [0:65535];
  bit          wr_seen  [0:65535];

  addr_t pkt_base [N_PKT];
  int    pkt_len  [N_PKT];
  dest_t pkt_dest [N_PKT];
  user_t pkt_user [N_PKT];
  // Packets whose descriptor is still expected, oldest first
  int    desc_q   [$];

  axis_wr_dma i_dut (.*);

  always #4 clk = ~clk;

  // Galois LFSR, one step per bit taken, newest bit lands in the LSB
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000);
      v    = {v[30:0], b};
    end
    return v;
  endfunction

  task automatic report_error(input int kind, input string msg);
    errs[kind]++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic show_counts();
    $display("Error counts: data %0d, descriptor %0d, handshake %0d, reset %0d",
             errs[E_DATA], errs[E_DESC], errs[E_HS], errs[E_RST]);
  endtask

  ////////////////////
  // Stimulus

  // Moves to the next falling edge and drives the ready pattern of the group
  task automatic next_cycle();
    @(negedge clk);
    mem_wr_ready    = 1'b1;
    recv_desc_ready = 1'b1;
    if (group == 2) begin
      mem_wr_ready = (rand_bits(1) != 0);
    end
    if (group == 3) begin
      recv_desc_ready = (rand_bits(2) == 0);
    end
  endtask

  task automatic send_packet(input int p);
    int nbeats;
    int idx;
    nbeats = (pkt_len[p] + DATA_BYTES - 1) / DATA_BYTES;
    for (int b = 0; b < nbeats; b++) begin
      // Full beats, then the tail with contiguous low bytes
      for (int k = 0; k < DATA_BYTES; k++) begin
        idx                    = b * DATA_BYTES + k;
        s_axis_tkeep[k]        = (idx < pkt_len[p]);
        s_axis_tdata[8*k +: 8] = s_axis_tkeep[k] ? exp_byte[pkt_base[p] + addr_t'(idx)] : 8'h00;
      end
      s_axis_tvalid = 1'b1;
      s_axis_tlast  = (b == nbeats - 1);
      s_axis_tdest  = pkt_dest[p];
      s_axis_tuser  = pkt_user[p];
      wr_base_addr  = pkt_base[p];
      next_cycle();
      while (!beat_taken) begin
        next_cycle();
      end
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  ////////////////////
  // Monitors

  // Every strobed byte must belong to a packet, match it, and arrive only once
  task automatic check_write();
    addr_t a;
    logic  hit_last;
    hit_last = 1'b0;
    for (int i = 0; i < DATA_BYTES; i++) begin
      if (mem_wr_strb[i]) begin
        a = mem_wr_addr + addr_t'(i);
        assert (exp_set[a])
          else report_error(E_DATA, $sformatf("byte 0x%h strobed outside any packet", a));
        assert (!wr_seen[a])
          else report_error(E_DATA, $sformatf("byte 0x%h written twice", a));
        assert (mem_wr_data[8*i +: 8] === exp_byte[a])
          else report_error(E_DATA, $sformatf("byte 0x%h is 0x%h, expected 0x%h",
                                              a, mem_wr_data[8*i +: 8], exp_byte[a]));
        wr_seen[a] = 1'b1;
        wr_mem[a]  = mem_wr_data[8*i +: 8];
        hit_last   = hit_last | exp_last[a];
      end
    end
    assert (mem_wr_last === hit_last)
      else report_error(E_DATA, $sformatf("mem_wr_last is %b at 0x%h, expected %b",
                                          mem_wr_last, mem_wr_addr, hit_last));
  endtask

  task automatic check_desc();
    int p;
    assert (desc_q.size() > 0)
      else report_error(E_DESC, "descriptor issued with no packet outstanding");
    if (desc_q.size() > 0) begin
      p = desc_q.pop_front();
      assert (recv_desc_addr === pkt_base[p])
        else report_error(E_DESC, $sformatf("packet %0d addr 0x%h, expected 0x%h",
                                            p, recv_desc_addr, pkt_base[p]));
      assert (recv_desc_len === len_t'(pkt_len[p]))
        else report_error(E_DESC, $sformatf("packet %0d len %0d, expected %0d",
                                            p, recv_desc_len, pkt_len[p]));
      assert (recv_desc_tdest === pkt_dest[p] && recv_desc_tuser === pkt_user[p])
        else report_error(E_DESC, $sformatf("packet %0d tags 0x%h/%0d, expected 0x%h/%0d",
                                            p, recv_desc_tdest, recv_desc_tuser,
                                            pkt_dest[p], pkt_user[p]));
    end
    desc_cnt++;
  endtask

  always @(posedge clk) begin
    beat_taken <= s_axis_tvalid && s_axis_tready;
    if (!rst && mem_wr_en && mem_wr_ready) begin
      check_write();
    end
    if (!rst && recv_desc_valid && recv_desc_ready) begin
      check_desc();
    end
  end

  // Write port holds still while memory stalls
  assert property (@(posedge clk) disable iff (rst)
    mem_wr_en && !mem_wr_ready |=> mem_wr_en && $stable(mem_wr_addr) && $stable(mem_wr_data)
      && $stable(mem_wr_strb) && $stable(mem_wr_last))
    else report_error(E_HS, "write port changed during a memory stall");

  // A pending descriptor keeps its fields until the consumer takes it
  assert property (@(posedge clk) disable iff (rst)
    recv_desc_valid && !recv_desc_ready |=> recv_desc_valid && $stable(recv_desc_addr)
      && $stable(recv_desc_len) && $stable(recv_desc_tdest) && $stable(recv_desc_tuser))
    else report_error(E_HS, "descriptor changed before it was taken");

  assert property (@(posedge clk) disable iff (rst)
    s_axis_tvalid && s_axis_tready && s_axis_tlast |-> !(recv_desc_valid && !recv_desc_ready))
    else report_error(E_HS, "last beat accepted while a descriptor was pending");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, %0d of %0d descriptors received",
               cycles, desc_cnt, N_PKT);
      show_counts();
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Test sequence

  initial begin
    int ofs;
    int total_beats;
    rst             = 1'b1;
    s_axis_tdata    = '0;
    s_axis_tkeep    = '0;
    s_axis_tvalid   = 1'b0;
    s_axis_tlast    = 1'b0;
    s_axis_tdest    = '0;
    s_axis_tuser    = '0;
    wr_base_addr    = '0;
    mem_wr_ready    = 1'b1;
    recv_desc_ready = 1'b1;
    group           = 0;
    total_beats     = 0;

    // First group uses word aligned bases, the rest any byte offset
    for (int p = 0; p < N_PKT; p++) begin
      pkt_len[p] = 1 + int'(rand_bits(6) % 40);
      if (p < N_GROUP) begin
        ofs = 8 * int'(rand_bits(2));
      end else begin
        ofs = int'(rand_bits(4));
      end
      pkt_base[p] = addr_t'(p * REGION + ofs);
      pkt_dest[p] = dest_t'(rand_bits(DEST_W));
      pkt_user[p] = user_t'(rand_bits(USER_W));
      for (int k = 0; k < pkt_len[p]; k++) begin
        exp_byte[pkt_base[p] + addr_t'(k)] = 8'(rand_bits(8));
        exp_set[pkt_base[p] + addr_t'(k)]  = 1'b1;
      end
      exp_last[pkt_base[p] + addr_t'(pkt_len[p] - 1)] = 1'b1;
      total_beats += (pkt_len[p] + DATA_BYTES - 1) / DATA_BYTES;
      desc_q.push_back(p);
    end
    limit = 4 * total_beats + 200;

    repeat (16) begin
      @(negedge clk);
      assert (mem_wr_en === 1'b0 && recv_desc_valid === 1'b0)
        else report_error(E_RST, "write enable or descriptor valid high during reset");
    end
    rst = 1'b0;
    next_cycle();
    assert (mem_wr_en === 1'b0 && recv_desc_valid === 1'b0)
      else report_error(E_RST, "write enable or descriptor valid high after reset");

    for (int p = 0; p < N_PKT; p++) begin
      group = p / N_GROUP;
      // Idle gaps let the FSM fall back to idle between packets
      if (group == 2) begin
        repeat (rand_bits(2)) next_cycle();
      end
      send_packet(p);
    end

    group = 0;
    while (desc_cnt < N_PKT) begin
      next_cycle();
    end
    repeat (4) next_cycle();

    // Anything never written is a lost byte
    for (int p = 0; p < N_PKT; p++) begin
      for (int k = 0; k < pkt_len[p]; k++) begin
        assert (wr_seen[pkt_base[p] + addr_t'(k)] &&
                wr_mem[pkt_base[p] + addr_t'(k)] === exp_byte[pkt_base[p] + addr_t'(k)])
          else report_error(E_DATA, $sformatf("packet %0d byte %0d missing in memory", p, k));
      end
    end

    show_counts();
    if (errs[E_DATA] + errs[E_DESC] + errs[E_HS] + errs[E_RST] == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/axis_wr_dma.sv ====
`timescale 1ns/1ps

module axis_wr_dma import dma_pkg::*; (
  input  logic  clk,
  input  logic  rst,

  // Incoming AXI-Stream packets
  input  data_t s_axis_tdata,
  input  keep_t s_axis_tkeep,
  input  logic  s_axis_tvalid,
  output logic  s_axis_tready,
  input  logic  s_axis_tlast,
  input  dest_t s_axis_tdest,
  input  user_t s_axis_tuser,

  // Byte address of the packet, sampled with its first beat
  input  addr_t wr_base_addr,

  // Memory write port
  output logic  mem_wr_en,
  output keep_t mem_wr_strb,
  output addr_t mem_wr_addr,
  output data_t mem_wr_data,
  output logic  mem_wr_last,
  input  logic  mem_wr_ready,

  // Receive descriptor
  output logic  recv_desc_valid,
  input  logic  recv_desc_ready,
  output addr_t recv_desc_addr,
  output len_t  recv_desc_len,
  output dest_t recv_desc_tdest,
  output user_t recv_desc_tuser
);

  logic desc_block;

  wr_ctrl_if wr_ctrl ();

  wr_rx_ctrl i_rx_ctrl (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tdest  (s_axis_tdest),
    .s_axis_tuser  (s_axis_tuser),
    .wr_base_addr  (wr_base_addr),
    .mem_wr_ready  (mem_wr_ready),
    .desc_block    (desc_block),
    .s_axis_tready (s_axis_tready),
    .mem_wr_en     (mem_wr_en),
    .ctrl          (wr_ctrl.ctrl)
  );

  wr_realign i_realign (
    .clk          (clk),
    .rst          (rst),
    .s_axis_tdata (s_axis_tdata),
    .s_axis_tkeep (s_axis_tkeep),
    .dp           (wr_ctrl.dpath),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_strb  (mem_wr_strb)
  );

  wr_desc_gen i_desc_gen (
    .clk             (clk),
    .rst             (rst),
    .mem_wr_strb     (mem_wr_strb),
    .recv_desc_ready (recv_desc_ready),
    .dsc             (wr_ctrl.desc),
    .mem_wr_addr     (mem_wr_addr),
    .desc_block      (desc_block),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_addr  (recv_desc_addr),
    .recv_desc_len   (recv_desc_len),
    .recv_desc_tdest (recv_desc_tdest),
    .recv_desc_tuser (recv_desc_tuser)
  );

  // Last word flag comes straight from the controller
  assign mem_wr_last = wr_ctrl.last_word;

endmodule

// ==== rtl/wr_desc_gen.sv ====
`timescale 1ns/1ps

module wr_desc_gen import dma_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  keep_t   mem_wr_strb,
  input  logic    recv_desc_ready,
  wr_ctrl_if.desc dsc,
  output addr_t   mem_wr_addr,
  output logic    desc_block,
  output logic    recv_desc_valid,
  output addr_t   recv_desc_addr,
  output len_t    recv_desc_len,
  output dest_t   recv_desc_tdest,
  output user_t   recv_desc_tuser
);

  addr_t   next_addr;
  addr_t   aligned_addr;
  bcount_t byte_cnt;
  len_t    pkt_len;
  len_t    pkt_len_n;
  logic    desc_valid_r;

  ////////////////////
  // Write address

  // First word goes to the word holding the base byte
  assign aligned_addr = {dsc.start_addr[ADDR_W-1:OFS_BITS], {OFS_BITS{1'b0}}};
  assign mem_wr_addr  = dsc.first ? aligned_addr : next_addr;

  always_ff @(posedge clk) begin
    if (dsc.advance) begin
      next_addr <= mem_wr_addr + addr_t'(DATA_BYTES);
    end
  end

  ////////////////////
  // Packet length

  // Strobes may have holes, so every bit is counted
  always_comb begin
    byte_cnt = '0;
    for (int i = 0; i < DATA_BYTES; i++) begin
      byte_cnt = byte_cnt + bcount_t'(mem_wr_strb[i]);
    end
  end

  // Running total restarts with the first word of each packet
  assign pkt_len_n = dsc.first ? len_t'(byte_cnt) : pkt_len + len_t'(byte_cnt);

  always_ff @(posedge clk) begin
    if (dsc.advance) begin
      pkt_len <= pkt_len_n;
    end
  end

  ////////////////////
  // Receive descriptor

  // The controller holds back a packet end while this one waits, so no overwrite
  always_ff @(posedge clk) begin
    if (dsc.advance && dsc.last_word) begin
      recv_desc_addr  <= dsc.start_addr;
      recv_desc_len   <= pkt_len_n;
      recv_desc_tdest <= dsc.tdest;
      recv_desc_tuser <= dsc.tuser;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid_r <= 1'b0;
    end else if (dsc.advance && dsc.last_word) begin
      desc_valid_r <= 1'b1;
    end else if (recv_desc_ready) begin
      desc_valid_r <= 1'b0;
    end
  end

  assign recv_desc_valid = desc_valid_r;
  assign desc_block      = desc_valid_r && !recv_desc_ready;

endmodule

// ==== rtl/wr_realign.sv ====
`timescale 1ns/1ps

module wr_realign import dma_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  data_t    s_axis_tdata,
  input  keep_t    s_axis_tkeep,
  wr_ctrl_if.dpath dp,
  output data_t    mem_wr_data,
  output keep_t    mem_wr_strb
);

  // Stage one is the newest beat, stage two the one before it
  data_t                   data_1;
  data_t                   data_2;
  keep_t                   strb_1;
  keep_t                   strb_2;
  logic [2*DATA_W-1:0]     data_cat;
  logic [2*DATA_BYTES-1:0] strb_cat;

  ////////////////////
  // Two stage pipeline

  always_ff @(posedge clk) begin
    if (dp.push) begin
      data_1 <= s_axis_tdata;
    end
    if (dp.advance) begin
      data_2 <= data_1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      strb_1 <= '0;
      strb_2 <= '0;
    end else begin
      // Extra tail word, nothing new enters stage one
      if (dp.flush) begin
        strb_1 <= '0;
      end else if (dp.push) begin
        strb_1 <= s_axis_tkeep;
      end
      // Leftovers of a finished packet must not leak into the next one
      if (dp.advance && dp.last_word) begin
        strb_2 <= '0;
      end else if (dp.advance) begin
        strb_2 <= strb_1;
      end
    end
  end

  ////////////////////
  // Byte shifter

  // Memory word is a DATA_BYTES window into the two stages, moved down by shift
  assign data_cat = {data_1, data_2} >> {dp.shift, 3'b000};
  assign strb_cat = {strb_1, strb_2} >> dp.shift;

  assign mem_wr_data = data_cat[DATA_W-1:0];
  assign mem_wr_strb = strb_cat[DATA_BYTES-1:0];

endmodule

// ==== rtl/wr_rx_ctrl.sv ====
`timescale 1ns/1ps

module wr_rx_ctrl import dma_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    s_axis_tvalid,
  input  logic    s_axis_tlast,
  input  keep_t   s_axis_tkeep,
  input  dest_t   s_axis_tdest,
  input  user_t   s_axis_tuser,
  input  addr_t   wr_base_addr,
  input  logic    mem_wr_ready,
  input  logic    desc_block,
  output logic    s_axis_tready,
  output logic    mem_wr_en,
  wr_ctrl_if.ctrl ctrl
);

  rx_state_e state;
  rx_state_e state_n;
  logic      push;
  logic      advance;
  logic      latch_info;
  logic      last_word;
  logic      extra_beat;
  logic      extra_beat_r;
  // tlast of the beat sitting in stage one
  logic      tail_last;
  // Stage one holds bytes that fall past the current output word
  logic      bytes_left;
  logic      first_r;
  logic      wr_en_r;
  shift_t    shift_r;
  shift_t    base_shift;

  assign push    = s_axis_tvalid && s_axis_tready;
  assign advance = wr_en_r && mem_wr_ready;

  // The last beat still has bytes beyond the window, so one more word is needed
  assign extra_beat = tail_last && bytes_left;

  // Either the last beat fits in this word, or this is the extra tail word
  assign last_word = wr_en_r && ((tail_last && !extra_beat) || extra_beat_r);

  // A new packet starts when idle, or right as the previous last word leaves
  assign latch_info = ((state == RX_IDLE) || (last_word && mem_wr_ready)) && push;

  // Shift for the packet being opened, taken from the low base address bits
  assign base_shift = shift_t'(DATA_BYTES) - shift_t'(wr_base_addr[OFS_BITS-1:0]);

  ////////////////////
  // Receive FSM

  always_comb begin
    state_n = state;
    case (state)
      RX_IDLE: begin
        if (push) begin
          state_n = RX_PROC;
        end
      end
      RX_PROC: begin
        // Stay busy when the next packet starts back to back
        if (last_word && mem_wr_ready && !push) begin
          state_n = RX_IDLE;
        end
      end
      default: state_n = RX_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RX_IDLE;
    end else begin
      state <= state_n;
    end
  end

  ////////////////////
  // Packet metadata

  always_ff @(posedge clk) begin
    if (latch_info) begin
      shift_r         <= base_shift;
      ctrl.start_addr <= wr_base_addr;
      ctrl.tdest      <= s_axis_tdest;
      ctrl.tuser      <= s_axis_tuser;
    end
  end

  // Looked up one cycle early so the extra beat decision is a register
  always_ff @(posedge clk) begin
    if (rst) begin
      bytes_left <= 1'b0;
    end else if (extra_beat && advance) begin
      bytes_left <= 1'b0;
    end else if (latch_info) begin
      bytes_left <= |(s_axis_tkeep >> base_shift);
    end else if (push) begin
      bytes_left <= |(s_axis_tkeep >> shift_r);
    end
  end

  ////////////////////
  // Pipeline control

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_last    <= 1'b0;
      extra_beat_r <= 1'b0;
      wr_en_r      <= 1'b0;
      first_r      <= 1'b0;
    end else begin
      // The flush empties stage one, so its tlast goes with it
      if (extra_beat && advance) begin
        tail_last <= 1'b0;
      end else if (push) begin
        tail_last <= s_axis_tlast;
      end
      if (advance) begin
        extra_beat_r <= extra_beat;
      end
      // A word is pending after each beat, after an extra beat, or while stalled
      wr_en_r <= push || (advance && extra_beat) || (wr_en_r && !mem_wr_ready);
      // First word flag follows stage one and holds through a stall
      first_r <= latch_info || (first_r && !mem_wr_ready);
    end
  end

  // No input during the extra beat, and no packet end while a descriptor waits
  // or while the previous packet's descriptor is being issued in this cycle
  assign s_axis_tready = mem_wr_ready && !extra_beat
                         && !(s_axis_tlast && (desc_block || last_word));
  assign mem_wr_en     = wr_en_r;

  assign ctrl.push      = push;
  assign ctrl.advance   = advance;
  assign ctrl.flush     = extra_beat && advance;
  assign ctrl.first     = first_r;
  assign ctrl.last_word = last_word;
  assign ctrl.shift     = shift_r;

endmodule

// ==== rtl/wr_ctrl_if.sv ====
`timescale 1ns/1ps

interface wr_ctrl_if import dma_pkg::*; ();

  // Input beat taken and memory word taken in this cycle
  logic   push;
  logic   advance;
  // Extra tail word goes out, stage one is emptied instead of loaded
  logic   flush;
  // Position of the word currently offered to memory
  logic   first;
  logic   last_word;
  // Byte shift and metadata captured with the first beat
  shift_t shift;
  addr_t  start_addr;
  dest_t  tdest;
  user_t  tuser;

  modport ctrl (
    output push, advance, flush, first, last_word,
    output shift, start_addr, tdest, tuser
  );

  modport dpath (input push, advance, flush, last_word, shift);

  modport desc (input advance, first, last_word, start_addr, tdest, tuser);

endinterface

// ==== rtl/dma_pkg.sv ====
package dma_pkg;

  ////////////////////
  // Widths

  // Bytes in one data word and the bits needed to index them
  localparam int DATA_BYTES = 8;
  localparam int OFS_BITS   = $clog2(DATA_BYTES);
  localparam int DATA_W     = DATA_BYTES * 8;

  // Address, length and sideband widths
  localparam int ADDR_W     = 16;
  localparam int LEN_W      = 16;
  localparam int DEST_W     = 8;
  localparam int USER_W     = 2;

  ////////////////////
  // Types

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [DATA_BYTES-1:0] keep_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [LEN_W-1:0]      len_t;
  typedef logic [DEST_W-1:0]     dest_t;
  typedef logic [USER_W-1:0]     user_t;

  // Realignment shift runs from 0 to DATA_BYTES, so it needs one extra bit
  typedef logic [OFS_BITS:0]     shift_t;
  // Set strobe bits in one word, 0 to DATA_BYTES
  typedef logic [OFS_BITS:0]     bcount_t;

  // Receive FSM, idle between packets and busy while one is in flight
  typedef enum logic [0:0] {
    RX_IDLE = 1'b0,
    RX_PROC = 1'b1
  } rx_state_e;

endpackage
